// ==== tb/ovc_alloc_stimulus.txt ====
# op class dest(binary) vc grant name
# A: vc is the expected grant; R: vc to release; B: vc released to unblock, grant expected
A 3 0100 2 0 pref_vc2_class3
A 0 1000 0 0 class0_masks_vc3
A 1 0100 1 0 fallback_pref_busy
R 0 0000 0 0 release_vc0
A 0 0010 0 0 regrant_vc0
B 0 0001 1 1 block_class0
R 0 0000 2 0 release_vc2
A 2 1000 3 0 pref_vc3_class2
A 2 0000 2 0 zero_dest_fallback
R 0 0000 0 0 release_all_vc0
R 0 0000 1 0 release_all_vc1
R 0 0000 2 0 release_all_vc2
R 0 0000 3 0 release_all_vc3
A 3 0000 0 0 zero_dest_vc0
A 3 0001 1 0 pref_vc0_busy
A 1 0010 2 0 class1_only_vc2
B 1 0001 2 2 block_class1
R 0 0000 1 0 release_vc1
A 1 0100 1 0 class1_fallback_vc1
A 3 0100 3 0 last_free_vc3
B 3 1000 3 3 block_class3
R 0 0000 0 0 final_release_vc0
R 0 0000 1 0 final_release_vc1
R 0 0000 2 0 final_release_vc2
R 0 0000 3 0 final_release_vc3

// ==== verilog.f ====
+incdir+source
source/noc_pkg.sv
source/ovc_status_if.sv
source/class_ovc_table.sv
source/vc_priority_based_dest_port.sv
source/ovc_status.sv
source/ovc_alloc_ctrl.sv
source/ovc_allocator.sv
tb/tb_ovc_allocator.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f verilog.f --top-module tb_ovc_allocator -o sim_tb_ovc_allocator

./obj_dir/sim_tb_ovc_allocator > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    exit 1
fi

// ==== tb/tb_ovc_allocator.sv ====
`include "noc_cfg.svh"

module tb_ovc_allocator;

    timeunit 1ns;
    timeprecision 100ps;

    // input driven at one edge, response at the next, seen at the second falling edge
    localparam int RISE_CYCLES = 2;

    logic                clk;
    logic                rst;
    logic                req;
    noc_pkg::class_t     class_in;
    noc_pkg::dest_port_t dest_port;
    logic                ack;
    noc_pkg::vc_id_t     grant_vc;
    logic                rel_req;
    noc_pkg::vc_id_t     rel_vc;
    logic                rel_ack;

    logic [`NOC_V-1:0] model_busy; // busy bits as the testbench expects them
    int                seed;

    ovc_allocator ovc_allocator_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .class_in  (class_in),
        .dest_port (dest_port),
        .ack       (ack),
        .grant_vc  (grant_vc),
        .rel_req   (rel_req),
        .rel_vc    (rel_vc),
        .rel_ack   (rel_ack)
    );

    always #2 clk = ~clk;

    task automatic value_mismatch(input string name, input int exp, input int act);
        $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic sig_value(input int sel);
        return (sel == 0) ? ack : rel_ack;
    endfunction

    // VCs a class may use, straight from the class setting
    function automatic logic [`NOC_V-1:0] allowed_mask(input int cls);
        logic [`NOC_C*`NOC_V-1:0] setting;
        setting = `NOC_CLASS_SETTING;
        return setting[cls*`NOC_V +: `NOC_V];
    endfunction

    // lowest free VC that is also preferred, else lowest free, -1 if none
    function automatic int expected_grant(input int cls, input int dest,
                                          input logic [`NOC_V-1:0] busy);
        logic [`NOC_V-1:0] prio;
        logic [`NOC_V-1:0] free;
        logic [`NOC_V-1:0] both;
        int                g;
        prio = (dest == 0) ? `NOC_V'(1) : `NOC_V'(dest); // 4 destinations on 4 VCs
        free = allowed_mask(cls) & ~busy;
        both = free & prio;
        g = -1;
        for (int i = 0; i < `NOC_V; i++) begin
            if (g < 0 && both[i]) begin
                g = i;
            end
        end
        for (int i = 0; i < `NOC_V; i++) begin
            if (g < 0 && free[i]) begin
                g = i;
            end
        end
        return g;
    endfunction

    // sel 0 is ack, sel 1 is rel_ack; sampled on the falling edge
    task automatic wait_for(input int sel, input logic level, input int limit,
                            input string name, output int cycles);
        int n;
        bit done;
        n = 0;
        done = 0;
        while (!done) begin
            @(negedge clk);
            n++;
            if (sig_value(sel) == level) begin
                done = 1;
            end else if (n >= limit) begin
                report_error($sformatf("%s: timeout after %0d cycles waiting for %s to be %0d",
                                       name, n, (sel == 0) ? "ack" : "rel_ack", level));
            end
        end
        cycles = n;
    endtask

    task automatic start_request(input int cls, input int dest);
        @(posedge clk);
        req       <= 1'b1;
        class_in  <= noc_pkg::class_t'(cls);
        dest_port <= noc_pkg::dest_port_t'(dest);
    endtask

    task automatic complete_request(input int cls, input int exp, input int rise_cycles,
                                    input string name);
        int                n;
        int                hold;
        logic [`NOC_V-1:0] allowed;
        wait_for(0, 1'b1, 30, name, n);
        if (rise_cycles > 0) begin
            assert (n == rise_cycles) else
                value_mismatch({name, " ack rise cycles"}, rise_cycles, n);
        end
        allowed = allowed_mask(cls);
        assert (allowed[grant_vc]) else
            report_error($sformatf("%s: VC %0d is outside the class %0d set",
                                   name, grant_vc, cls));
        assert (int'(grant_vc) == exp) else value_mismatch(name, exp, int'(grant_vc));
        // ack and grant_vc must hold under requester back-pressure
        hold = {$random(seed)} % 4;
        repeat (hold) begin
            @(negedge clk);
            assert (ack) else report_error($sformatf("%s: ack dropped while req high", name));
            assert (int'(grant_vc) == exp) else value_mismatch(name, exp, int'(grant_vc));
        end
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        assert (ack) else
            report_error($sformatf("%s: ack fell before req was sampled low", name));
        wait_for(0, 1'b0, 10, name, n);
        assert (n == 1) else value_mismatch({name, " ack fall cycles"}, 1, n);
        model_busy[exp] = 1'b1;
    endtask

    task automatic release_vc(input int vc, input string name);
        int n;
        assert (model_busy[vc]) else
            report_error($sformatf("%s: stimulus releases VC %0d which is not allocated",
                                   name, vc));
        @(posedge clk);
        rel_vc  <= noc_pkg::vc_id_t'(vc);
        rel_req <= 1'b1;
        wait_for(1, 1'b1, 10, name, n);
        assert (n == RISE_CYCLES) else
            value_mismatch({name, " rel_ack rise cycles"}, RISE_CYCLES, n);
        @(posedge clk);
        rel_req <= 1'b0;
        @(negedge clk);
        assert (rel_ack) else
            report_error($sformatf("%s: rel_ack fell before rel_req was sampled low", name));
        wait_for(1, 1'b0, 10, name, n);
        assert (n == 1) else value_mismatch({name, " rel_ack fall cycles"}, 1, n);
        model_busy[vc] = 1'b0;
    endtask

    initial begin
        int    fd;
        int    n_fields;
        int    cls;
        int    dest;
        int    vc;
        int    grant;
        int    m;
        int    ops;
        string line;
        string op;
        string name;

        clk        = 1'b0;
        rst        = 1'b1;
        req        = 1'b0;
        class_in   = '0;
        dest_port  = '0;
        rel_req    = 1'b0;
        rel_vc     = '0;
        model_busy = '0;
        seed       = 90;
        ops        = 0;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!ack && !rel_ack) else report_error("ack or rel_ack high after reset");

        fd = $fopen("tb/ovc_alloc_stimulus.txt", "r");
        if (fd == 0) begin
            report_error("cannot open tb/ovc_alloc_stimulus.txt");
        end

        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                n_fields = $sscanf(line, "%s %d %b %d %d %s", op, cls, dest, vc, grant, name);
                if (n_fields != 6) begin
                    report_error($sformatf("malformed stimulus line: %s", line));
                end
                ops++;
                if (op == "A") begin
                    m = expected_grant(cls, dest, model_busy);
                    assert (m == vc) else value_mismatch({name, " stimulus vs model"}, m, vc);
                    start_request(cls, dest);
                    complete_request(cls, vc, RISE_CYCLES, name);
                end else if (op == "R") begin
                    release_vc(vc, name);
                end else if (op == "B") begin
                    m = expected_grant(cls, dest, model_busy);
                    assert (m < 0) else
                        report_error($sformatf("%s: stimulus expects a block but VC %0d is free",
                                               name, m));
                    start_request(cls, dest);
                    repeat (20) begin
                        @(negedge clk);
                        assert (!ack) else
                            report_error($sformatf("%s: ack while all allowed VCs busy", name));
                    end
                    release_vc(vc, name); // served from WAIT_VC
                    m = expected_grant(cls, dest, model_busy);
                    assert (m == grant) else
                        value_mismatch({name, " stimulus vs model"}, m, grant);
                    complete_request(cls, grant, 0, name); // latency depends on the release
                end else begin
                    report_error($sformatf("unknown opcode %s in stimulus", op));
                end
            end
        end
        $fclose(fd);

        if (ops == 0) begin
            report_error("stimulus file held no operations");
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== source/ovc_allocator.sv ====
`include "noc_cfg.svh"

module ovc_allocator (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    input  noc_pkg::class_t     class_in,
    input  noc_pkg::dest_port_t dest_port,
    output logic                ack,
    output noc_pkg::vc_id_t     grant_vc,
    input  logic                rel_req,
    input  noc_pkg::vc_id_t     rel_vc,
    output logic                rel_ack
);

    noc_pkg::vc_mask_t candidate_ovcs; // VCs the class may use
    noc_pkg::vc_mask_t vc_priority;    // VCs preferred for the destination

    ovc_status_if st_if ();

    class_ovc_table #(
        .C             (`NOC_C),
        .V             (`NOC_V),
        .CLASS_SETTING (`NOC_CLASS_SETTING)
    ) class_ovc_table_i (
        .class_in       (class_in),
        .candidate_ovcs (candidate_ovcs)
    );

    vc_priority_based_dest_port #(
        .P (`NOC_P),
        .V (`NOC_V)
    ) vc_priority_based_dest_port_i (
        .dest_port   (dest_port),
        .vc_priority (vc_priority)
    );

    ovc_alloc_ctrl ovc_alloc_ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .req            (req),
        .rel_req        (rel_req),
        .rel_vc         (rel_vc),
        .candidate_ovcs (candidate_ovcs),
        .vc_priority    (vc_priority),
        .ack            (ack),
        .grant_vc       (grant_vc),
        .rel_ack        (rel_ack),
        .st             (st_if.ctrl)
    );

    ovc_status ovc_status_i (
        .clk (clk),
        .rst (rst),
        .st  (st_if.status)
    );

endmodule

// ==== source/ovc_alloc_ctrl.sv ====
module ovc_alloc_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              req,
    input  logic              rel_req,
    input  noc_pkg::vc_id_t   rel_vc,
    input  noc_pkg::vc_mask_t candidate_ovcs,
    input  noc_pkg::vc_mask_t vc_priority,
    output logic              ack,
    output noc_pkg::vc_id_t   grant_vc,
    output logic              rel_ack,
    ovc_status_if.ctrl        st
);

    noc_pkg::alloc_state_t state;
    noc_pkg::alloc_state_t state_nxt;
    noc_pkg::vc_mask_t     free;
    noc_pkg::vc_mask_t     preferred;
    noc_pkg::vc_id_t       pick;
    logic                  alloc_en;
    logic                  rel_en;
    logic                  rel_start;

    function automatic noc_pkg::vc_id_t lowest_set(input noc_pkg::vc_mask_t m);
        noc_pkg::vc_id_t idx;
        idx = '0;
        for (int i = $bits(m) - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = noc_pkg::vc_id_t'(i);
            end
        end
        return idx;
    endfunction

    assign free      = candidate_ovcs & ~st.busy;
    assign preferred = free & vc_priority;
    assign pick      = (preferred != '0) ? lowest_set(preferred) : lowest_set(free);
    assign rel_start = rel_req && !rel_ack; // new release, not the one already acked

    always_comb begin
        state_nxt = state;
        alloc_en  = 1'b0;
        rel_en    = 1'b0;
        case (state)
            noc_pkg::IDLE: begin
                if (req) begin // requests win over releases
                    if (free != '0) begin
                        alloc_en  = 1'b1;
                        state_nxt = noc_pkg::GRANT;
                    end else begin
                        state_nxt = noc_pkg::WAIT_VC;
                    end
                end else if (rel_start) begin
                    rel_en    = 1'b1;
                    state_nxt = noc_pkg::REL_ACK;
                end
            end
            noc_pkg::WAIT_VC: begin
                if (free != '0) begin
                    alloc_en  = 1'b1;
                    state_nxt = noc_pkg::GRANT;
                end else if (rel_start) begin
                    rel_en = 1'b1; // serve releases here or we never unblock
                end
            end
            noc_pkg::GRANT: begin
                if (!req) begin
                    state_nxt = noc_pkg::IDLE;
                end
            end
            noc_pkg::REL_ACK: begin
                if (!rel_req) begin
                    state_nxt = noc_pkg::IDLE;
                end
            end
            default: state_nxt = noc_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= noc_pkg::IDLE;
            ack     <= 1'b0;
            rel_ack <= 1'b0;
        end else begin
            state <= state_nxt;
            if (alloc_en) begin
                ack <= 1'b1;
            end else if (state == noc_pkg::GRANT && !req) begin
                ack <= 1'b0;
            end
            // rel_ack may still be high after WAIT_VC has moved on
            if (rel_en) begin
                rel_ack <= 1'b1;
            end else if (rel_ack && !rel_req) begin
                rel_ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            grant_vc <= pick;
        end
    end

    assign st.alloc_en = alloc_en;
    assign st.alloc_vc = pick;
    assign st.rel_en   = rel_en;
    assign st.rel_vc   = rel_vc;

    a_grant_stable: assert property (
        @(posedge clk) disable iff (rst)
        ack |=> !ack || $stable(grant_vc)
    ) else $error("ovc_alloc_ctrl: grant_vc changed while ack high");

    a_no_ack_idle: assert property (
        @(posedge clk) disable iff (rst)
        state == noc_pkg::IDLE |-> !ack
    ) else $error("ovc_alloc_ctrl: ack high in IDLE");

endmodule

// ==== source/ovc_status.sv ====
module ovc_status (
    input logic          clk,
    input logic          rst,
    ovc_status_if.status st
);

    noc_pkg::vc_mask_t busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (st.alloc_en) begin
                busy[st.alloc_vc] <= 1'b1;
            end
            if (st.rel_en) begin
                busy[st.rel_vc] <= 1'b0; // tail flit has left
            end
        end
    end

    assign st.busy = busy;

    // controller must only pick from the free set it computed
    a_alloc_free: assert property (
        @(posedge clk) disable iff (rst)
        st.alloc_en |-> !busy[st.alloc_vc]
    ) else $error("ovc_status: allocate of busy VC %0d", st.alloc_vc);

    // a release has to match an earlier grant
    a_release_busy: assert property (
        @(posedge clk) disable iff (rst)
        st.rel_en |-> busy[st.rel_vc]
    ) else $error("ovc_status: release of idle VC %0d", st.rel_vc);

endmodule

// ==== source/vc_priority_based_dest_port.sv ====
module vc_priority_based_dest_port #(
    parameter int P = 5,
    parameter int V = 4
) (
    input  logic [P-2:0] dest_port,
    output logic [V-1:0] vc_priority
);

    localparam int P_1    = P - 1;   // destinations seen from one input
    localparam int OFFSET = V / P_1;

    logic [V-1:0] prio_raw;

    generate
        if (P_1 == V) begin : g_direct
            assign prio_raw = dest_port; // one VC per destination
        end else if (P_1 > V) begin : g_merge
            wire [V-1:0] merged;

            // several destinations share one VC
            for (genvar i = 0; i < V; i++) begin : g_vc
                assign merged[i] = |dest_port[((i + 1) * P_1) / V - 1 : (i * P_1) / V];
            end

            assign prio_raw = merged;
        end else begin : g_spread
            always_comb begin
                prio_raw = '0;
                for (int j = 0; j < P_1; j++) begin
                    prio_raw[j + OFFSET] = dest_port[j];
                end
            end
        end
    endgenerate

    // no destination bit set falls back to VC 0
    assign vc_priority = (prio_raw == '0) ? V'(1) : prio_raw;

endmodule

// ==== source/class_ovc_table.sv ====
module class_ovc_table #(
    parameter int C = 4,
    parameter int V = 4,
    parameter logic [((C == 0) ? V : C * V)-1:0] CLASS_SETTING = '1
) (
    input  logic [$clog2((C > 1) ? C : 2)-1:0] class_in,
    output logic [V-1:0]                       candidate_ovcs
);

    generate
        if (C <= 1) begin : g_no_class
            assign candidate_ovcs = '1; // no classes, every VC allowed
        end else begin : g_class
            wire [V-1:0] class_table [C];

            // one V-bit group of the setting per class
            for (genvar i = 0; i < C; i++) begin : g_slice
                assign class_table[i] = CLASS_SETTING[i*V +: V];
            end

            assign candidate_ovcs = class_table[class_in];
        end
    endgenerate

endmodule

// ==== source/ovc_status_if.sv ====
interface ovc_status_if;

    logic              alloc_en; // set busy[alloc_vc]
    noc_pkg::vc_id_t   alloc_vc;
    logic              rel_en;   // clear busy[rel_vc]
    noc_pkg::vc_id_t   rel_vc;
    noc_pkg::vc_mask_t busy;

    modport ctrl (
        output alloc_en,
        output alloc_vc,
        output rel_en,
        output rel_vc,
        input  busy
    );

    modport status (
        input  alloc_en,
        input  alloc_vc,
        input  rel_en,
        input  rel_vc,
        output busy
    );

endinterface

// ==== source/noc_pkg.sv ====
`include "noc_cfg.svh"

package noc_pkg;

    // traffic class number
    typedef logic [$clog2(`NOC_C)-1:0] class_t;

    // one-hot destination, the input port itself is not a destination
    typedef logic [`NOC_P-2:0] dest_port_t;

    typedef logic [`NOC_V-1:0] vc_mask_t; // one bit per output VC

    typedef logic [$clog2(`NOC_V)-1:0] vc_id_t;

    // allocation controller FSM
    typedef enum logic [1:0] {
        IDLE,    // waiting for req or rel_req
        WAIT_VC, // request pending, no allowed VC free
        GRANT,   // ack high until req drops
        REL_ACK  // rel_ack high until rel_req drops
    } alloc_state_t;

endpackage

// ==== source/noc_cfg.svh ====
`ifndef NOC_CFG_SVH
`define NOC_CFG_SVH

`define NOC_C 4 // traffic classes
`define NOC_V 4 // VCs per output port
`define NOC_P 5 // router ports, local port included

// one NOC_V bit group per class, class 0 in the low bits
// class 3: all VCs, class 2: VCs 2-3, class 1: VCs 1-2, class 0: VCs 0-1
`define NOC_CLASS_SETTING 16'b1111_1100_0110_0011

`endif
